/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_l2_top
RTL_TOP    := l2_top
FILELIST   := vlog.f
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall --timescale 1ns/1ps
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/l2_array_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_defs.svh"

interface l2_array_if;

    logic [`L2_INDEX_W+`L2_WAY_W-1:0] line;    // {index, way}
    logic                             refill;
    logic                             update;
    logic                             rd_en;
    logic [`L2_DATA_W-1:0]            fill_data; // word from memory
    logic [`L2_DATA_W-1:0]            wr_data;   // word from L1
    logic [`L2_DATA_W-1:0]            q;

    modport ctrl (
        output line, refill, update, rd_en, fill_data, wr_data,
        input  q
    );

    modport array (
        input  line, refill, update, rd_en, fill_data, wr_data,
        output q
    );

endinterface

`default_nettype wire

/* common/l2_defs.svh */
`ifndef L2_DEFS_SVH
`define L2_DEFS_SVH

// address split of an L1 request
`define L2_TAG_W    18
`define L2_INDEX_W  8      // 256 sets

// associativity
`define L2_WAYS     4
`define L2_WAY_W    2

// one data word per line
`define L2_DATA_W   32

// sets times ways
`define L2_LINES    1024

`endif

/* common/l2_pkg.sv */
`default_nettype none

package l2_pkg;

    // controller states
    typedef enum logic [1:0] {
        S_IDLE       = 2'b00,
        S_COMPARE    = 2'b01,
        S_WRITE_BACK = 2'b10,
        S_ALLOCATE   = 2'b11
    } l2_state_t;

    // request toward main memory
    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_READ  = 2'b01,
        MEM_WRITE = 2'b10
    } mem_op_t;

endpackage

`default_nettype wire

/* dv/l2_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_defs.svh"

module l2_mem_model (
    input  wire                        clk,
    input  wire                        nrst,
    input  wire [7:0]                  delay,     // cycles until mem_ready
    input  wire                        mem_read,
    input  wire                        mem_write,
    input  wire [`L2_INDEX_W-1:0]      mem_index,
    input  wire [`L2_TAG_W-1:0]        mem_tag,
    input  wire [`L2_DATA_W-1:0]       mem_wdata,
    output logic                       mem_ready,
    output logic [`L2_DATA_W-1:0]      mem_rdata
);

    import l2_pkg::*;

    logic [`L2_DATA_W-1:0] store [logic [`L2_TAG_W+`L2_INDEX_W-1:0]];
    logic [`L2_TAG_W+`L2_INDEX_W-1:0] addr;
    logic [7:0] wait_cnt;
    mem_op_t    op;

    assign addr = {mem_tag, mem_index};
    assign op   = mem_write ? MEM_WRITE : (mem_read ? MEM_READ : MEM_NONE);

    // unwritten words hash the full address
    function automatic logic [`L2_DATA_W-1:0] initial_word(
        input logic [`L2_TAG_W+`L2_INDEX_W-1:0] a);
        return ({6'b0, a} * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    always @(negedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            wait_cnt  <= '0;
        end
        else if (mem_ready)
        begin
            mem_ready <= 1'b0;  // one cycle pulse
            wait_cnt  <= '0;
        end
        else if (op != MEM_NONE)
        begin
            if (wait_cnt + 8'd1 >= delay)
            begin
                mem_ready <= 1'b1;
                if (op == MEM_WRITE)
                    store[addr] = mem_wdata;
                else if (store.exists(addr))
                    mem_rdata <= store[addr];
                else
                    mem_rdata <= initial_word(addr);
            end
            else
                wait_cnt <= wait_cnt + 8'd1;
        end
    end

endmodule

`default_nettype wire

/* dv/tb_l2_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_defs.svh"

module tb_l2_top;

    import l2_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_REQ    = 80;   // upper bound on requests issued

    logic clk = 1'b0;
    logic nrst;
    logic read, write, flush;
    logic [`L2_TAG_W-1:0]   tag;
    logic [`L2_INDEX_W-1:0] index;
    logic [`L2_DATA_W-1:0]  wdata;
    wire                    ready, mem_read, mem_write, mem_ready;
    wire [`L2_DATA_W-1:0]   rdata, mem_wdata, mem_rdata;
    wire [`L2_INDEX_W-1:0]  mem_index;
    wire [`L2_TAG_W-1:0]    mem_tag;
    logic [7:0] mem_delay;

    logic [31:0] lfsr = 32'h8a1c;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int err_mark;
    int long_delay = 0;

    // reference state, per set and way
    logic [`L2_TAG_W-1:0]  ref_tag  [256][4];
    logic [`L2_DATA_W-1:0] ref_data [256][4];
    bit ref_valid [256][4];
    bit ref_dirty [256][4];
    int ref_rank  [256][4];
    logic [`L2_DATA_W-1:0] ref_mem [logic [`L2_TAG_W+`L2_INDEX_W-1:0]];

    // memory transfers seen on the bus
    mem_op_t seen_op [$];
    logic [`L2_TAG_W+`L2_INDEX_W-1:0] seen_addr [$];
    logic [`L2_DATA_W-1:0] seen_data [$];
    logic prev_rd = 1'b0;
    logic prev_wr = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    l2_top u_l2_top (
        .clk (clk), .nrst (nrst), .read (read), .write (write), .flush (flush),
        .tag (tag), .index (index), .wdata (wdata), .ready (ready), .rdata (rdata),
        .mem_read (mem_read), .mem_write (mem_write), .mem_index (mem_index),
        .mem_tag (mem_tag), .mem_wdata (mem_wdata), .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    l2_mem_model u_mem (
        .clk (clk), .nrst (nrst), .delay (mem_delay), .mem_read (mem_read),
        .mem_write (mem_write), .mem_index (mem_index), .mem_tag (mem_tag),
        .mem_wdata (mem_wdata), .mem_ready (mem_ready), .mem_rdata (mem_rdata)
    );

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] mem_expect(input logic [25:0] a);
        if (ref_mem.exists(a))
            return ref_mem[a];
        return ({6'b0, a} * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic int find_way(input logic [17:0] t, input logic [7:0] s);
        int w;
        w = -1;
        for (int i = 3; i >= 0; i--)
            if (ref_valid[s][i] && ref_tag[s][i] == t)
                w = i;
        return w;
    endfunction

    function automatic int pick_victim(input logic [7:0] s);
        int w;
        w = -1;
        for (int i = 3; i >= 0; i--)
            if (!ref_valid[s][i])
                w = i;
        for (int i = 0; i < 4 && w < 0; i++)
            if (ref_rank[s][i] == 3)
                w = i;
        return w;
    endfunction

    function automatic void touch_rank(input logic [7:0] s, input int w);
        int old;
        old = ref_rank[s][w];
        for (int i = 0; i < 4; i++)
            if (i == w)
                ref_rank[s][i] = 0;
            else if (ref_rank[s][i] < old)
                ref_rank[s][i]++;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // strobes hold until mem_ready, ready never overlaps a transfer
    always @(negedge clk)
    begin
        if (nrst)
        begin
            assert (!((prev_rd && !mem_ready && !mem_read) || (prev_wr && !mem_ready && !mem_write)))
            else
            begin
                errors++;
                $display("memory strobe dropped before mem_ready at %0t", $time);
            end
            assert (!(ready && (mem_read || mem_write)))
            else
            begin
                errors++;
                $display("ready pulsed while a memory transfer was open at %0t", $time);
            end
            if (mem_write && !prev_wr)
            begin
                seen_op.push_back(MEM_WRITE);
                seen_addr.push_back({mem_tag, mem_index});
                seen_data.push_back(mem_wdata);
            end
            if (mem_read && !prev_rd)
            begin
                seen_op.push_back(MEM_READ);
                seen_addr.push_back({mem_tag, mem_index});
                seen_data.push_back('0);
            end
        end
        prev_rd = mem_read;
        prev_wr = mem_write;
    end

    task automatic access(input logic is_write, input logic [17:0] t, input logic [7:0] s,
                          input logic [31:0] wd);
        int way;
        int cycles;
        bit exp_hit;
        logic [31:0] exp_rd;
        mem_op_t exp_op [$];
        logic [25:0] exp_addr [$];
        logic [31:0] exp_data [$];
        way = find_way(t, s);
        exp_hit = (way >= 0);
        if (!exp_hit)
        begin
            way = pick_victim(s);
            if (ref_valid[s][way] && ref_dirty[s][way])
            begin
                exp_op.push_back(MEM_WRITE);
                exp_addr.push_back({ref_tag[s][way], s});
                exp_data.push_back(ref_data[s][way]);
                ref_mem[{ref_tag[s][way], s}] = ref_data[s][way];
            end
            exp_op.push_back(MEM_READ);
            exp_addr.push_back({t, s});
            exp_data.push_back('0);
            ref_tag[s][way] = t;
            ref_valid[s][way] = 1'b1;
            ref_dirty[s][way] = 1'b0;
            ref_data[s][way] = mem_expect({t, s});
        end
        touch_rank(s, way);
        exp_rd = ref_data[s][way];
        if (is_write)
        begin
            ref_data[s][way] = wd;
            ref_dirty[s][way] = 1'b1;
        end

        mem_delay = (long_delay != 0) ? 8'(long_delay) : 8'(rand_bits(2) + 1);
        seen_op.delete();
        seen_addr.delete();
        seen_data.delete();
        @(negedge clk);
        read = ~is_write;
        write = is_write;
        tag = t;
        index = s;
        wdata = wd;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!ready);
        if (!is_write)
            check_eq(rdata, exp_rd, "read data");
        read = 1'b0;
        write = 1'b0;

        if (exp_hit)
            check_eq(cycles, 2, "hit latency");
        check_eq(seen_op.size(), exp_op.size(), "memory transfer count");
        for (int i = 0; i < exp_op.size() && i < seen_op.size(); i++)
        begin
            check_eq(32'(seen_op[i]), 32'(exp_op[i]), "memory opcode");
            check_eq(32'(seen_addr[i]), 32'(exp_addr[i]), "memory tag and index");
            if (exp_op[i] == MEM_WRITE)
                check_eq(seen_data[i], exp_data[i], "write-back data");
        end
    endtask

    task automatic flush_all();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        for (int s = 0; s < 256; s++)
            for (int w = 0; w < 4; w++)
            begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d failures", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        nrst = 1'b1;
        read = 1'b0;
        write = 1'b0;
        flush = 1'b0;
        tag = '0;
        index = '0;
        wdata = '0;
        mem_delay = 8'd1;
        for (int s = 0; s < 256; s++)
            for (int w = 0; w < 4; w++)
            begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_rank[s][w] = w;
            end
        #1 nrst = 1'b0;
        repeat (16) @(negedge clk);
        nrst = 1'b1;
        err_mark = errors;

        access(1'b0, 18'h2aaaa, 8'h05, 32'h0);
        access(1'b0, 18'h2aaaa, 8'h05, 32'h0);
        end_test("read miss then hit");

        access(1'b1, 18'h2aaaa, 8'h05, 32'hcafe_0001);
        access(1'b0, 18'h2aaaa, 8'h05, 32'h0);
        end_test("write hit");

        access(1'b1, 18'h001a0, 8'h21, 32'hdead_beef);
        for (int i = 1; i <= 4; i++)
            access(1'b0, 18'h001a0 + 18'(i), 8'h21, 32'h0);
        access(1'b0, 18'h001a0, 8'h21, 32'h0);   // comes back from memory
        end_test("dirty eviction");

        for (int i = 0; i < 4; i++)
            access(1'b0, 18'h00100 + 18'(i), 8'h4c, 32'h0);
        for (int i = 0; i < 6; i++)
            access(1'b0, 18'h00100 + 18'(rand_bits(2)), 8'h4c, 32'h0);
        access(1'b0, 18'h00104, 8'h4c, 32'h0);
        for (int i = 0; i < 4; i++)
            access(1'b0, 18'h00100 + 18'(i), 8'h4c, 32'h0);
        end_test("lru order");

        access(1'b1, 18'h00104, 8'h4c, 32'h1234_5678);
        flush_all();
        access(1'b0, 18'h2aaaa, 8'h05, 32'h0);   // dirty word never reached memory
        for (int i = 0; i < 5; i++)
            access(1'b0, 18'h001a0 + 18'(i), 8'h21, 32'h0);
        for (int i = 0; i < 5; i++)
            access(1'b0, 18'h00100 + 18'(i), 8'h4c, 32'h0);
        end_test("flush");

        long_delay = 9;
        for (int i = 1; i <= 4; i++)
            access(1'b1, 18'(i), 8'h90, 32'hb00c_0000 + 32'(i));
        access(1'b0, 18'h00005, 8'h90, 32'h0);
        long_delay = 0;
        for (int i = 0; i < 24; i++)
            access(rand_bits(1) == 1, 18'h03000 + 18'(rand_bits(3)), 8'h90 + 8'(rand_bits(1)),
                   rand_bits(32));
        end_test("back-pressure");

        $display("%0d tests, %0d checks, %0d failures", tests, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        #(CLK_PERIOD * (16 + 200 * NUM_REQ));
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* l2_cache/l2_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_defs.svh"

module l2_controller (
    input  wire                    clk,
    input  wire                    nrst,
    input  wire                    read,
    input  wire                    write,
    input  wire                    flush,
    input  wire [`L2_TAG_W-1:0]    tag,
    input  wire [`L2_INDEX_W-1:0]  index,
    input  wire [`L2_DATA_W-1:0]   wdata,
    input  wire                    mem_ready,
    input  wire [`L2_DATA_W-1:0]   mem_rdata,
    output logic                   ready,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic [`L2_INDEX_W-1:0] mem_index,
    output logic [`L2_TAG_W-1:0]   mem_tag,
    l2_array_if.ctrl               arr
);

    import l2_pkg::*;

    l2_state_t state;
    l2_state_t next_state;
    mem_op_t   mem_op;

    logic [`L2_TAG_W-1:0] tags [0:`L2_LINES-1];
    logic [`L2_LINES-1:0] valid;
    logic [`L2_LINES-1:0] dirty;

    logic [`L2_WAYS-1:0]  match;
    logic                 hit;
    logic [`L2_WAY_W-1:0] hit_way;
    logic [`L2_WAY_W-1:0] victim_way;
    logic [`L2_WAY_W-1:0] way_q;      // victim held across write-back and allocate
    logic                 victim_dirty;
    logic                 wb_done;
    logic                 alloc_done;
    logic                 flush_go;

    logic [`L2_INDEX_W+`L2_WAY_W-1:0] hit_line;
    logic [`L2_INDEX_W+`L2_WAY_W-1:0] vict_line;
    logic [`L2_INDEX_W+`L2_WAY_W-1:0] way_line;

    assign hit_line  = {index, hit_way};
    assign vict_line = {index, victim_way};
    assign way_line  = {index, way_q};

    // tag compare on the registered arrays
    always_comb
    begin
        match   = '0;
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
            match[w] = valid[{index, `L2_WAY_W'(w)}] && (tags[{index, `L2_WAY_W'(w)}] == tag);
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (match[w])
                hit_way = `L2_WAY_W'(w);
        end
    end

    assign hit          = (state == S_COMPARE) && (read || write) && (|match);
    assign victim_dirty = valid[vict_line] && dirty[vict_line];
    assign wb_done      = (state == S_WRITE_BACK) && mem_ready;
    assign alloc_done   = (state == S_ALLOCATE) && mem_ready;
    assign flush_go     = (state == S_IDLE) && flush && !read && !write;

    l2_lru u_lru (
        .clk        (clk),
        .nrst       (nrst),
        .set        (index),
        .touch      (hit),
        .touch_way  (hit_way),
        .valid_mask (valid[{index, `L2_WAY_W'(0)} +: `L2_WAYS]),
        .victim_way (victim_way)
    );

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
                // ready cycle still shows the old request
                if ((read || write) && !ready)
                    next_state = S_COMPARE;
            S_COMPARE:
                if (hit)
                    next_state = S_IDLE;
                else if (victim_dirty)
                    next_state = S_WRITE_BACK;
                else
                    next_state = S_ALLOCATE;
            S_WRITE_BACK:
                if (mem_ready)
                    next_state = S_ALLOCATE;
            S_ALLOCATE:
                if (mem_ready)
                    next_state = S_COMPARE;
            default:
                next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            way_q <= '0;
        else if ((state == S_COMPARE) && !hit)
            way_q <= victim_way;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (flush_go)
        begin
            valid <= '0;   // dirty lines are dropped too
            dirty <= '0;
        end
        else
        begin
            if (alloc_done)
                valid[way_line] <= 1'b1;
            if (wb_done)
                dirty[way_line] <= 1'b0;
            if (hit && write)
                dirty[hit_line] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (alloc_done)
            tags[way_line] <= tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            ready <= 1'b0;
        else
            ready <= hit;
    end

    always_comb
    begin
        case (state)
            S_WRITE_BACK: mem_op = MEM_WRITE;
            S_ALLOCATE:   mem_op = MEM_READ;
            default:      mem_op = MEM_NONE;
        endcase
    end

    assign mem_read  = (mem_op == MEM_READ);
    assign mem_write = (mem_op == MEM_WRITE);
    assign mem_index = index;
    assign mem_tag   = (state == S_WRITE_BACK) ? tags[way_line] : tag;

    // a miss reads the victim early so q holds it for the write-back
    always_comb
    begin
        if (state == S_COMPARE)
            arr.line = hit ? hit_line : vict_line;
        else
            arr.line = way_line;
    end

    assign arr.rd_en     = (hit && read) || ((state == S_COMPARE) && !hit)
                           || (state == S_WRITE_BACK);
    assign arr.update    = hit && write;
    assign arr.refill    = alloc_done;
    assign arr.wr_data   = wdata;
    assign arr.fill_data = mem_rdata;

endmodule

`default_nettype wire

/* l2_cache/l2_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_defs.svh"

module l2_data_array (
    input  wire        clk,
    input  wire        nrst,
    l2_array_if.array  arr
);

    logic [`L2_DATA_W-1:0] words [0:`L2_LINES-1];

    // refill and update never come together
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < `L2_LINES; i++)
                words[i] <= '0;
        end
        else if (arr.refill)
        begin
            words[arr.line] <= arr.fill_data;
        end
        else if (arr.update)
        begin
            words[arr.line] <= arr.wr_data;
        end
    end

    // registered read port
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            arr.q <= '0;
        else if (arr.rd_en)
            arr.q <= words[arr.line];
    end

endmodule

`default_nettype wire

/* l2_cache/l2_lru.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_defs.svh"

module l2_lru (
    input  wire                    clk,
    input  wire                    nrst,
    input  wire [`L2_INDEX_W-1:0]  set,
    input  wire                    touch,
    input  wire [`L2_WAY_W-1:0]    touch_way,
    input  wire [`L2_WAYS-1:0]     valid_mask,
    output logic [`L2_WAY_W-1:0]   victim_way
);

    // rank 0 is most recent, rank 3 the oldest
    logic [`L2_WAY_W-1:0] rank [0:`L2_LINES/`L2_WAYS-1][0:`L2_WAYS-1];
    logic [`L2_WAY_W-1:0] lru_way;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < `L2_LINES / `L2_WAYS; s++)
                for (int w = 0; w < `L2_WAYS; w++)
                    rank[s][w] <= `L2_WAY_W'(w);   // way 3 starts oldest
        end
        else if (touch)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
            begin
                if (`L2_WAY_W'(w) == touch_way)
                    rank[set][w] <= '0;
                else if (rank[set][w] < rank[set][touch_way])
                    rank[set][w] <= rank[set][w] + 1'b1;   // age the younger ones
            end
        end
    end

    always_comb
    begin
        lru_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (rank[set][w] == '1)
                lru_way = `L2_WAY_W'(w);
        end

        // an empty way beats the LRU one, lowest first
        victim_way = lru_way;
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (!valid_mask[w])
                victim_way = `L2_WAY_W'(w);
        end
    end

endmodule

`default_nettype wire

/* source/l2_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_defs.svh"

module l2_top (
    input  wire                    clk,
    input  wire                    nrst,
    input  wire                    read,
    input  wire                    write,
    input  wire                    flush,
    input  wire [`L2_TAG_W-1:0]    tag,
    input  wire [`L2_INDEX_W-1:0]  index,
    input  wire [`L2_DATA_W-1:0]   wdata,
    output wire                    ready,
    output wire [`L2_DATA_W-1:0]   rdata,
    output wire                    mem_read,
    output wire                    mem_write,
    output wire [`L2_INDEX_W-1:0]  mem_index,
    output wire [`L2_TAG_W-1:0]    mem_tag,
    output wire [`L2_DATA_W-1:0]   mem_wdata,
    input  wire                    mem_ready,
    input  wire [`L2_DATA_W-1:0]   mem_rdata
);

    l2_array_if arr_if ();

    l2_controller u_controller (
        .clk       (clk),
        .nrst      (nrst),
        .read      (read),
        .write     (write),
        .flush     (flush),
        .tag       (tag),
        .index     (index),
        .wdata     (wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .ready     (ready),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_index (mem_index),
        .mem_tag   (mem_tag),
        .arr       (arr_if.ctrl)
    );

    l2_data_array u_data_array (
        .clk  (clk),
        .nrst (nrst),
        .arr  (arr_if.array)
    );

    // q serves both the L1 read and the write-back word
    assign rdata     = arr_if.q;
    assign mem_wdata = arr_if.q;

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/l2_pkg.sv
common/l2_array_if.sv
l2_cache/l2_lru.sv
l2_cache/l2_data_array.sv
l2_cache/l2_controller.sv
source/l2_top.sv
dv/l2_mem_model.sv
dv/tb_l2_top.sv
